// File: hdl/fp32_consts.svh
`ifndef FP32_CONSTS_SVH
`define FP32_CONSTS_SVH

// binary32 field widths
`define FP32_EXP_W      8
`define FP32_MAN_W      23

// significand with hidden bit plus guard, round and sticky
`define FP32_EXT_W      27

// all-ones exponent marks infinity and NaN
`define FP32_EXP_MAX    255

// canonical quiet NaN returned for every invalid sum
`define FP32_QNAN       32'h7fc00000

// cycles from input strobe to output strobe
`define FP32_PIPE_LAT   3

`endif

// File: hdl/fp32_pkg.sv
`include "fp32_consts.svh"

package fp32_pkg;

    // raw binary32 word
    typedef logic [31:0] fp32_t;

    // biased exponent field
    typedef logic [`FP32_EXP_W-1:0] exp_t;

    // significand including the hidden bit
    typedef logic [`FP32_MAN_W:0] mant_t;

    // significand followed by guard, round, sticky
    typedef logic [`FP32_EXT_W-1:0] ext_mant_t;

    // extended sum with room for the carry
    typedef logic [`FP32_EXT_W:0] sum_t;

    // signed working exponent, wide enough to see over- and underflow
    typedef logic signed [`FP32_EXP_W+1:0] norm_exp_t;

    // stage 1 -> stage 2
    typedef struct packed {
        logic      valid;
        logic      sign;
        exp_t      exp;
        ext_mant_t mant_big;
        ext_mant_t mant_small;
        logic      eff_sub;
        logic      is_special;
        fp32_t     special_value;
    } align_stage_t;

    // stage 2 -> stage 3
    typedef struct packed {
        logic      valid;
        logic      sign;
        norm_exp_t exp;
        ext_mant_t mant;
        logic      is_zero;
        logic      is_special;
        fp32_t     special_value;
    } norm_stage_t;

endpackage

// File: hdl/fp32_align.sv
`include "fp32_consts.svh"

module fp32_align import fp32_pkg::*; (
    input  logic         s_clk,
    input  logic         i_reset,
    input  logic         i_data_valid,
    input  fp32_t        i_data1,
    input  fp32_t        i_data2,
    output align_stage_t o_stage
);

    logic         zero1;
    logic         zero2;
    logic         inf1;
    logic         inf2;
    logic         nan1;
    logic         nan2;
    logic         swap;
    fp32_t        op_big;
    fp32_t        op_small;
    exp_t         exp_diff;
    logic [4:0]   shift_amt;
    mant_t        man_big;
    mant_t        man_small;
    logic [53:0]  shift_wide;
    ext_mant_t    aligned;
    logic         is_special;
    fp32_t        special_value;
    align_stage_t stage_d;

    // classification, subnormals count as zero
    assign zero1 = (i_data1[30:23] == '0);
    assign zero2 = (i_data2[30:23] == '0);
    assign inf1  = (i_data1[30:23] == exp_t'(`FP32_EXP_MAX)) && (i_data1[22:0] == '0);
    assign inf2  = (i_data2[30:23] == exp_t'(`FP32_EXP_MAX)) && (i_data2[22:0] == '0);
    assign nan1  = (i_data1[30:23] == exp_t'(`FP32_EXP_MAX)) && (i_data1[22:0] != '0);
    assign nan2  = (i_data2[30:23] == exp_t'(`FP32_EXP_MAX)) && (i_data2[22:0] != '0);

    // order by magnitude, exponent and fraction compare as one integer
    assign swap     = (i_data2[30:0] > i_data1[30:0]);
    assign op_big   = swap ? i_data2 : i_data1;
    assign op_small = swap ? i_data1 : i_data2;

    assign man_big   = {1'b1, op_big[22:0]};
    assign man_small = {1'b1, op_small[22:0]};
    assign exp_diff  = op_big[30:23] - op_small[30:23];

    // past 27 everything lands in sticky anyway
    assign shift_amt = (exp_diff > exp_t'(27)) ? 5'd27 : exp_diff[4:0];

    // upper half keeps the aligned bits, lower half catches what fell out
    assign shift_wide = {man_small, 3'b000, 27'd0} >> shift_amt;
    assign aligned    = {shift_wide[53:28], |shift_wide[27:0]};

    always_comb begin
        is_special    = 1'b1;
        special_value = `FP32_QNAN;
        if (nan1 || nan2 || (inf1 && inf2 && (i_data1[31] != i_data2[31]))) begin
            special_value = `FP32_QNAN;
        end else if (inf1) begin
            special_value = i_data1;
        end else if (inf2) begin
            special_value = i_data2;
        end else if (zero1 && zero2) begin
            // -0 only when both are negative
            special_value = {i_data1[31] & i_data2[31], 31'd0};
        end else if (zero1) begin
            special_value = i_data2;
        end else if (zero2) begin
            special_value = i_data1;
        end else begin
            is_special = 1'b0;
        end
    end

    always_comb begin
        stage_d.valid         = i_data_valid;
        stage_d.sign          = op_big[31];
        stage_d.exp           = op_big[30:23];
        stage_d.mant_big      = {man_big, 3'b000};
        stage_d.mant_small    = aligned;
        stage_d.eff_sub       = i_data1[31] ^ i_data2[31];
        stage_d.is_special    = is_special;
        stage_d.special_value = special_value;
    end

    always_ff @(posedge s_clk) begin
        o_stage <= stage_d;
        if (i_reset) begin
            o_stage.valid <= 1'b0;
        end
    end

    a_inputs_known: assert property (
        @(posedge s_clk) disable iff (i_reset)
        i_data_valid |-> !$isunknown({i_data1, i_data2})
    ) else $error("unknown operand bits with i_data_valid high");

endmodule

// File: hdl/fp32_add_norm.sv
module fp32_add_norm import fp32_pkg::*; (
    input  logic         s_clk,
    input  logic         i_reset,
    input  align_stage_t i_stage,
    output norm_stage_t  o_stage
);

    sum_t        sum;
    logic [4:0]  lz;
    norm_exp_t   exp_in;
    ext_mant_t   norm_mant;
    norm_exp_t   norm_exp;
    logic        sum_zero;
    norm_stage_t stage_d;

    // leading zeros of the 27-bit extended mantissa
    function automatic logic [4:0] count_lz(input ext_mant_t v);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = $bits(ext_mant_t) - 1; i >= 0; i--) begin
            if (!found && !v[i]) begin
                n = n + 5'd1;
            end else begin
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // big operand is never below small, so the difference stays positive
    assign sum = i_stage.eff_sub ? ({1'b0, i_stage.mant_big} - {1'b0, i_stage.mant_small})
                                 : ({1'b0, i_stage.mant_big} + {1'b0, i_stage.mant_small});

    assign sum_zero = (sum == '0);
    assign lz       = count_lz(sum[$bits(ext_mant_t)-1:0]);
    assign exp_in   = norm_exp_t'({2'b00, i_stage.exp});

    always_comb begin
        if (sum[$bits(sum_t)-1]) begin
            // carry out, shift right and fold the lost bit into sticky
            norm_mant = {sum[$bits(sum_t)-1:2], sum[1] | sum[0]};
            norm_exp  = exp_in + norm_exp_t'(1);
        end else begin
            norm_mant = sum[$bits(ext_mant_t)-1:0] << lz;
            norm_exp  = exp_in - norm_exp_t'({5'd0, lz});
        end
    end

    always_comb begin
        stage_d.valid         = i_stage.valid;
        // exact cancellation gives +0
        stage_d.sign          = sum_zero ? 1'b0 : i_stage.sign;
        stage_d.exp           = norm_exp;
        stage_d.mant          = norm_mant;
        stage_d.is_zero       = sum_zero;
        stage_d.is_special    = i_stage.is_special;
        stage_d.special_value = i_stage.special_value;
    end

    always_ff @(posedge s_clk) begin
        o_stage <= stage_d;
        if (i_reset) begin
            o_stage.valid <= 1'b0;
        end
    end

    a_normalized: assert property (
        @(posedge s_clk) disable iff (i_reset)
        i_stage.valid |=>
            (o_stage.is_zero || o_stage.is_special || o_stage.mant[$bits(ext_mant_t)-1])
    ) else $error("normalized mantissa lost its leading one");

endmodule

// File: hdl/fp32_round_pack.sv
`include "fp32_consts.svh"

module fp32_round_pack import fp32_pkg::*; (
    input  logic        s_clk,
    input  logic        i_reset,
    input  norm_stage_t i_stage,
    output logic        o_data_valid,
    output fp32_t       o_data
);

    logic        guard;
    logic        round_bit;
    logic        sticky;
    logic        lsb;
    logic        round_up;
    logic [24:0] rounded;
    norm_exp_t   exp_round;
    logic [22:0] frac;
    logic        overflow;
    logic        underflow;
    fp32_t       result;

    assign lsb       = i_stage.mant[3];
    assign guard     = i_stage.mant[2];
    assign round_bit = i_stage.mant[1];
    assign sticky    = i_stage.mant[0];

    // nearest even, a tie rounds up only on an odd lsb
    assign round_up = guard & (round_bit | sticky | lsb);
    assign rounded  = {1'b0, i_stage.mant[26:3]} + 25'(round_up);

    // carry out of rounding leaves 1.000..., so bump the exponent
    assign exp_round = i_stage.exp + norm_exp_t'({9'd0, rounded[24]});
    assign frac      = rounded[24] ? rounded[23:1] : rounded[22:0];

    assign overflow  = (exp_round >= norm_exp_t'(`FP32_EXP_MAX));
    assign underflow = (exp_round <= norm_exp_t'(0));

    always_comb begin
        if (i_stage.is_special) begin
            result = i_stage.special_value;
        end else if (i_stage.is_zero) begin
            result = {i_stage.sign, 31'd0};
        end else if (overflow) begin
            result = {i_stage.sign, exp_t'(`FP32_EXP_MAX), 23'd0};
        end else if (underflow) begin
            // flush, no subnormal output
            result = {i_stage.sign, 31'd0};
        end else begin
            result = {i_stage.sign, exp_round[7:0], frac};
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            o_data_valid <= 1'b0;
        end else begin
            o_data_valid <= i_stage.valid;
        end
    end

    always_ff @(posedge s_clk) begin
        o_data <= result;
    end

    // any NaN leaving the pipe is the canonical one
    a_canonical_nan: assert property (
        @(posedge s_clk) disable iff (i_reset)
        (o_data_valid && (o_data[30:23] == exp_t'(`FP32_EXP_MAX)) && (o_data[22:0] != '0))
            |-> (o_data == `FP32_QNAN)
    ) else $error("non-canonical NaN on o_data");

endmodule

// File: hdl/adder_fp32.sv
module adder_fp32 import fp32_pkg::*; (
    input  logic  s_clk,
    input  logic  i_reset,

    input  logic  i_data_valid,
    input  fp32_t i_data1,
    input  fp32_t i_data2,

    output logic  o_data_valid,
    output fp32_t o_data
);

    align_stage_t align_q;
    norm_stage_t  norm_q;

    // unpack, special detect, order and align
    fp32_align u_fp32_align (
        .s_clk         ( s_clk         ),
        .i_reset       ( i_reset       ),
        .i_data_valid  ( i_data_valid  ),
        .i_data1       ( i_data1       ),
        .i_data2       ( i_data2       ),
        .o_stage       ( align_q       )
    );

    // mantissa add or subtract, then normalize
    fp32_add_norm u_fp32_add_norm (
        .s_clk         ( s_clk         ),
        .i_reset       ( i_reset       ),
        .i_stage       ( align_q       ),
        .o_stage       ( norm_q        )
    );

    // round to nearest even and pack
    fp32_round_pack u_fp32_round_pack (
        .s_clk         ( s_clk         ),
        .i_reset       ( i_reset       ),
        .i_stage       ( norm_q        ),
        .o_data_valid  ( o_data_valid  ),
        .o_data        ( o_data        )
    );

endmodule

// File: sim/tb_adder_fp32.sv
`include "fp32_consts.svh"

module tb_adder_fp32 import fp32_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam string CASE_FILE   = "sim/fp32_adder_cases.txt";
    localparam int    MAX_CASES   = 64;
    localparam int    MAX_WORDS   = 3 * MAX_CASES;
    localparam int    DRAIN_LIMIT = 50;

    logic  s_clk;
    logic  i_reset;
    logic  i_data_valid;
    fp32_t i_data1;
    fp32_t i_data2;
    logic  o_data_valid;
    fp32_t o_data;

    // operand 1, operand 2, expected sum per case
    fp32_t case_mem [0:MAX_WORDS-1];
    int    num_cases;
    int    seed = 32'h94dd53a6;
    int    cycle = 0;

    // expected results in issue order
    fp32_t want_q [$];
    int    issue_q [$];
    int    index_q [$];

    adder_fp32 dut_i (
        .s_clk        ( s_clk        ),
        .i_reset      ( i_reset      ),
        .i_data_valid ( i_data_valid ),
        .i_data1      ( i_data1      ),
        .i_data2      ( i_data2      ),
        .o_data_valid ( o_data_valid ),
        .o_data       ( o_data       )
    );

    initial begin
        s_clk = 1'b0;
        forever #10 s_clk = ~s_clk;
    end

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
    end

    // marker left in unused words and unique per address
    function automatic fp32_t fill_word(input int addr);
        return 32'hbad00000 ^ fp32_t'(addr);
    endfunction

    task automatic compare_fp32(input fp32_t got, input fp32_t want, input int idx);
        if (got !== want) begin
            $display("** Error at %0t ns: case %0d sum %h, expected %h", $time, idx, got, want);
            $display("Simulation failed");
            $fatal(1, "sum mismatch");
        end
    endtask

    task automatic compare_latency(input int got, input int want, input int idx);
        if (got != want) begin
            $display("** Error at %0t ns: case %0d latency %0d cycles, expected %0d",
                     $time, idx, got, want);
            $display("Simulation failed");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic load_cases();
        int fd;
        for (int i = 0; i < MAX_WORDS; i++) begin
            case_mem[i] = fill_word(i);
        end
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("The case file %s could not be opened.", CASE_FILE);
            $display("Simulation failed");
            $fatal(1, "missing case file");
        end
        $fclose(fd);
        $readmemh(CASE_FILE, case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[3*num_cases] != fill_word(3*num_cases)) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("The case file %s holds no cases.", CASE_FILE);
            $display("Simulation failed");
            $fatal(1, "empty case file");
        end
    endtask

    task automatic drive_case(input int idx);
        @(posedge s_clk);
        #2;
        i_data_valid = 1'b1;
        i_data1      = case_mem[3*idx];
        i_data2      = case_mem[3*idx+1];
        want_q.push_back(case_mem[3*idx+2]);
        issue_q.push_back(cycle);
        index_q.push_back(idx);
    endtask

    task automatic drive_idle();
        @(posedge s_clk);
        #2;
        i_data_valid = 1'b0;
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge s_clk) begin
        if (!i_reset && o_data_valid === 1'b1) begin
            if (want_q.size() == 0) begin
                $display("A result %h appeared at %0t ns with no case outstanding.",
                         o_data, $time);
                $display("Simulation failed");
                $fatal(1, "unexpected output strobe");
            end else begin
                compare_fp32(o_data, want_q.pop_front(), index_q[0]);
                compare_latency(cycle - issue_q.pop_front(), `FP32_PIPE_LAT,
                                index_q.pop_front());
            end
        end
    end

    initial begin
        int gap;
        int waited;
        i_reset      = 1'b1;
        i_data_valid = 1'b0;
        i_data1      = '0;
        i_data2      = '0;
        load_cases();
        repeat (8) @(posedge s_clk);
        #2;
        i_reset = 1'b0;

        // first pass with random idle gaps
        for (int i = 0; i < num_cases; i++) begin
            drive_case(i);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) drive_idle();
        end
        drive_idle();

        // second pass back to back with three results in flight
        for (int i = 0; i < num_cases; i++) begin
            drive_case(i);
        end
        drive_idle();

        waited = 0;
        while (want_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge s_clk);
            waited++;
        end
        if (want_q.size() != 0) begin
            $display("Timed out with %0d results still missing after %0d cycles.",
                     want_q.size(), waited);
            $display("Simulation failed");
            $fatal(1, "drain timeout");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+hdl
hdl/fp32_pkg.sv
hdl/fp32_align.sv
hdl/fp32_add_norm.sv
hdl/fp32_round_pack.sv
hdl/adder_fp32.sv
sim/tb_adder_fp32.sv

// File: Makefile
# Verilator flow for the pipelined binary32 adder
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_adder_fp32
FILELIST  ?= build.f
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# a $fatal in the testbench makes the binary exit non-zero, so make fails too
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/fp32_adder_cases.txt
// columns: operand 1, operand 2, expected sum, all binary32 in hex
// round to nearest even, subnormal inputs count as zero
// same-sign normals, last one keeps only sticky
3f800000 3f800000 40000000
3f800000 40000000 40400000
bf800000 c0000000 c0400000
3f800000 3dcccccd 3f8ccccd
42c80000 3e800000 42c88000
3f800000 30800000 3f800000
// opposite signs and cancellation
3f800000 bf800000 00000000
3f800000 bf400000 3e800000
3f800001 bf800000 34000000
c0800000 3f800000 c0400000
3f800000 b3800000 3f7fffff
3f800000 b0800000 3f800000
// ties to even and rounding carry
3f800000 33800000 3f800000
3f800001 33800000 3f800002
3f800000 33c00000 3f800001
3fffffff 33800000 40000000
4b800001 3f800000 4b800002
// overflow, infinities, NaN, subnormals, underflow
7f7fffff 7f7fffff 7f800000
ff7fffff ff7fffff ff800000
7f800000 3f800000 7f800000
40000000 ff800000 ff800000
7f800000 ff800000 7fc00000
7fc00001 3f800000 7fc00000
3f800000 ffffffff 7fc00000
00000001 3f800000 3f800000
80000000 80000000 80000000
00800000 80800001 80000000
00c00000 80800000 00000000
